// File: design/mult_pkg.sv
/*
 * multiplier datapath widths
 * operand, product and partial-product row types
 */

`default_nettype none

package mult_pkg;

	// signed operand width
	localparam int OPERAND_W = 16;

	// full two's-complement product
	localparam int PRODUCT_W = 2 * OPERAND_W;

	// one row per radix-4 digit
	localparam int NUM_PP_ROWS = OPERAND_W / 2;

	typedef logic [OPERAND_W-1:0] operand_t;

	typedef logic [PRODUCT_W-1:0] product_t;

	// partial-product row, already aligned to product columns
	typedef logic [PRODUCT_W-1:0] pp_row_t;

endpackage

`default_nettype wire

// File: design/booth_pkg.sv
/*
 * radix-4 Booth recoding definitions
 * digit count, per-digit control vector, sign-extension constant
 */

`default_nettype none

package booth_pkg;

	// digits covering a 16-bit multiplier
	localparam int NUM_DIGITS = 8;

	// one control bit per digit
	typedef logic [NUM_DIGITS-1:0] digit_ctrl_t;

	// constant ones for the inverted-sign scheme
	// columns 16, 17 and every odd column above 17
	// equals -(2^16) * (1 + 4 + ... + 4^7) mod 2^32
	localparam logic [mult_pkg::PRODUCT_W-1:0] SIGN_EXT_ONES = 32'hAAAB_0000;

endpackage

`default_nettype wire

// File: design/booth_encoder.sv
/*
 * radix-4 Booth encoder
 * recodes the multiplier into zero, double and negate controls per digit
 */

`default_nettype none

module booth_encoder (
	input  wire mult_pkg::operand_t i_mr,
	output booth_pkg::digit_ctrl_t  o_zero,
	output booth_pkg::digit_ctrl_t  o_double,
	output booth_pkg::digit_ctrl_t  o_negate
);

	import mult_pkg::*;
	import booth_pkg::*;

	// implied zero below bit 0
	logic [OPERAND_W:0] mr_ext;

	assign mr_ext = {i_mr, 1'b0};

	for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
		logic [2:0] win;

		// overlapping window {b(2i+1), b(2i), b(2i-1)}
		assign win = mr_ext[2*i+2 -: 3];

		// 000 and 111 both select zero
		assign o_zero[i] = (win == 3'b000) | (win == 3'b111);

		// +2 for 011, -2 for 100
		assign o_double[i] = (win == 3'b011) | (win == 3'b100);

		// 111 is -0 and stays positive so no correction bit is added
		assign o_negate[i] = win[2] & ~(win[1] & win[0]);
	end

endmodule

`default_nettype wire

// File: design/pp_generator.sv
/*
 * Booth partial-product generator
 * eight shifted 17-bit rows with inverted sign bit
 * correction row with negation bits and sign-extension constant
 */

`default_nettype none

module pp_generator (
	input  wire mult_pkg::operand_t      i_md,
	input  wire booth_pkg::digit_ctrl_t  i_zero,
	input  wire booth_pkg::digit_ctrl_t  i_double,
	input  wire booth_pkg::digit_ctrl_t  i_negate,
	output mult_pkg::pp_row_t            o_rows [mult_pkg::NUM_PP_ROWS],
	output mult_pkg::pp_row_t            o_corr_row
);

	import mult_pkg::*;
	import booth_pkg::*;

	// one extra bit for the doubled multiplicand
	localparam int PP_W = OPERAND_W + 1;

	for (genvar i = 0; i < NUM_PP_ROWS; i++) begin : g_row
		operand_t        neg_md;
		operand_t        sel_md;
		logic [PP_W-1:0] pp;

		// one's complement with the +1 in the correction row
		assign neg_md = i_negate[i] ? ~i_md : i_md;
		assign sel_md = i_zero[i] ? '0 : neg_md;

		// doubling shifts the negate bit in at the bottom
		always_comb begin
			if (i_double[i]) begin
				pp = {~sel_md[OPERAND_W-1], sel_md[OPERAND_W-2:0], i_negate[i]};
			end
			else begin
				pp = {~sel_md[OPERAND_W-1], sel_md};
			end
		end

		// row i sits at column 2i
		assign o_rows[i] = pp_row_t'(pp) << (2 * i);
	end

	// negate bits land on even columns 0..14 below the constant
	always_comb begin
		o_corr_row = SIGN_EXT_ONES;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			o_corr_row[2*i] = i_negate[i];
		end
	end

endmodule

`default_nettype wire

// File: design/csa_row.sv
/*
 * carry-save adder row
 * full adder per column, three rows in, sum and carry rows out
 */

`default_nettype none

module csa_row (
	input  wire mult_pkg::pp_row_t i_a,
	input  wire mult_pkg::pp_row_t i_b,
	input  wire mult_pkg::pp_row_t i_c,
	output mult_pkg::pp_row_t      o_sum,
	output mult_pkg::pp_row_t      o_carry
);

	import mult_pkg::*;

	pp_row_t prop;
	pp_row_t carry_col;

	// per-column propagate
	assign prop = i_a ^ i_b;

	assign o_sum = prop ^ i_c;

	// majority of the three inputs
	assign carry_col = (i_a & i_b) | (prop & i_c);

	// carry weighs one column up and the top bit falls off
	assign o_carry = {carry_col[PRODUCT_W-2:0], 1'b0};

endmodule

`default_nettype wire

// File: design/compressor_row.sv
/*
 * 4:2 compressor row
 * one compressor cell per column, side carry passed to the next column
 * four rows in, sum and carry rows out
 */

`default_nettype none

module compressor_row (
	input  wire mult_pkg::pp_row_t i_a,
	input  wire mult_pkg::pp_row_t i_b,
	input  wire mult_pkg::pp_row_t i_c,
	input  wire mult_pkg::pp_row_t i_d,
	output mult_pkg::pp_row_t      o_sum,
	output mult_pkg::pp_row_t      o_carry
);

	import mult_pkg::*;

	pp_row_t ab_xor;
	pp_row_t cd_xor;
	pp_row_t all_xor;
	pp_row_t side_out;
	pp_row_t side_in;
	pp_row_t carry_col;

	assign ab_xor  = i_a ^ i_b;
	assign cd_xor  = i_c ^ i_d;
	assign all_xor = ab_xor ^ cd_xor;

	// side carry depends only on the four inputs so there is no long chain
	assign side_out = (i_a & i_b) | (i_c & i_d);

	// column j takes the side carry of column j-1 with zero into column 0
	assign side_in = {side_out[PRODUCT_W-2:0], 1'b0};

	assign o_sum = all_xor ^ side_in;

	assign carry_col = (i_a & i_b & i_c & i_d)
		| (ab_xor & cd_xor)
		| (all_xor & side_in);

	// carry output weighs one column up
	assign o_carry = {carry_col[PRODUCT_W-2:0], 1'b0};

endmodule

`default_nettype wire

// File: design/booth_multiplier.sv
/*
 * pipelined signed 16x16 radix-4 Booth multiplier
 * stage 0 with operand register, Booth rows and 9 to 4 row reduction
 * stage 1 with row register, 4 to 2 compression and final addition
 * i_start loads operands, o_ready flags a valid product
 */

`default_nettype none

module booth_multiplier (
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire                     i_start,
	input  wire mult_pkg::operand_t i_md,
	input  wire mult_pkg::operand_t i_mr,
	output mult_pkg::product_t      o_product,
	output logic                    o_ready
);

	import mult_pkg::*;
	import booth_pkg::*;

	// rows held across the pipeline register
	localparam int S1_ROWS = NUM_PP_ROWS / 2;

	operand_t    md_q;
	operand_t    mr_q;
	logic        valid_s0;

	digit_ctrl_t dig_zero;
	digit_ctrl_t dig_double;
	digit_ctrl_t dig_negate;

	pp_row_t     pp_rows [NUM_PP_ROWS];
	pp_row_t     corr_row;
	pp_row_t     csa_sum;
	pp_row_t     csa_carry;
	pp_row_t     s0_rows [S1_ROWS];
	pp_row_t     s1_rows [S1_ROWS];
	pp_row_t     fin_sum;
	pp_row_t     fin_carry;

	// operands only load on a start
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			md_q     <= '0;
			mr_q     <= '0;
			valid_s0 <= 1'b0;
		end
		else begin
			if (i_start) begin
				md_q <= i_md;
				mr_q <= i_mr;
			end
			valid_s0 <= i_start;
		end
	end

	booth_encoder u_booth_encoder (
		.i_mr     (mr_q),
		.o_zero   (dig_zero),
		.o_double (dig_double),
		.o_negate (dig_negate)
	);

	pp_generator u_pp_generator (
		.i_md       (md_q),
		.i_zero     (dig_zero),
		.i_double   (dig_double),
		.i_negate   (dig_negate),
		.o_rows     (pp_rows),
		.o_corr_row (corr_row)
	);

	// 9 to 8 rows
	csa_row u_csa_row (
		.i_a     (corr_row),
		.i_b     (pp_rows[0]),
		.i_c     (pp_rows[1]),
		.o_sum   (csa_sum),
		.o_carry (csa_carry)
	);

	// 8 to 4 rows
	compressor_row u_comp_lo (
		.i_a     (csa_sum),
		.i_b     (csa_carry),
		.i_c     (pp_rows[2]),
		.i_d     (pp_rows[3]),
		.o_sum   (s0_rows[0]),
		.o_carry (s0_rows[1])
	);

	compressor_row u_comp_hi (
		.i_a     (pp_rows[4]),
		.i_b     (pp_rows[5]),
		.i_c     (pp_rows[6]),
		.i_d     (pp_rows[7]),
		.o_sum   (s0_rows[2]),
		.o_carry (s0_rows[3])
	);

	// rows hold between starts so the product stays put
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			s1_rows <= '{default: '0};
			o_ready <= 1'b0;
		end
		else begin
			if (valid_s0) begin
				s1_rows <= s0_rows;
			end
			o_ready <= valid_s0;
		end
	end

	// 4 to 2 rows
	compressor_row u_comp_final (
		.i_a     (s1_rows[0]),
		.i_b     (s1_rows[1]),
		.i_c     (s1_rows[2]),
		.i_d     (s1_rows[3]),
		.o_sum   (fin_sum),
		.o_carry (fin_carry)
	);

	// carry-propagate add without carry out
	assign o_product = fin_sum + fin_carry;

endmodule

`default_nettype wire

// File: tb/tb_booth_multiplier.sv
/*
 * testbench for the pipelined Booth multiplier
 * clock, reset, LFSR operand stimulus, reference product model
 * comparison process with product and ready checks
 */

`default_nettype none

module tb_booth_multiplier;

	import mult_pkg::*;

	localparam int HALF_PERIOD = 50;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_DIRECTED = 14;
	localparam int NUM_B2B = 400;
	localparam int NUM_GAPPED = 300;
	localparam int DRAIN_LIMIT = 20;

	logic     i_clk = 1'b0;
	logic     i_rst;
	logic     i_start;
	operand_t i_md;
	operand_t i_mr;
	product_t o_product;
	logic     o_ready;

	logic [31:0] lfsr_state = 32'd80540;
	product_t    expected_q [$];
	product_t    last_product = '0;
	product_t    popped;
	logic        start_d1 = 1'b0;
	logic        start_d2 = 1'b0;
	int          checks_run = 0;
	int          value_errors = 0;
	int          other_errors = 0;
	int          drain_cycles;

	// corner pairs covering every Booth digit type in some multiplier
	operand_t dir_md [NUM_DIRECTED] = '{16'h0000, 16'h4321, 16'h0001, 16'hFFFF,
		16'h7FFF, 16'h8000, 16'h8000, 16'h7FFF, 16'h5555, 16'hAAAA,
		16'hAAAA, 16'h5555, 16'h3333, 16'hCCCC};
	operand_t dir_mr [NUM_DIRECTED] = '{16'h1234, 16'h0000, 16'hFFFF, 16'hFFFF,
		16'h7FFF, 16'h8000, 16'h7FFF, 16'h8000, 16'hAAAA, 16'h5555,
		16'hAAAA, 16'h5555, 16'hCCCC, 16'h3333};

	booth_multiplier dut_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start   (i_start),
		.i_md      (i_md),
		.i_mr      (i_mr),
		.o_product (o_product),
		.o_ready   (o_ready)
	);

	initial begin
		forever #HALF_PERIOD i_clk = ~i_clk;
	end

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	// signed product truncated to the product width
	function automatic product_t ref_product(input operand_t a, input operand_t b);
		logic signed [PRODUCT_W-1:0] sa;
		logic signed [PRODUCT_W-1:0] sb;
		sa = $signed(a);
		sb = $signed(b);
		return product_t'(sa * sb);
	endfunction

	task automatic check_product(input product_t got, input product_t want);
		checks_run++;
		if (got !== want) begin
			$display("[ERROR] o_product: got 0x%08h, expected 0x%08h", got, want);
			value_errors++;
		end
	endtask

	task automatic check_ready(input logic got, input logic want);
		checks_run++;
		if (got !== want) begin
			$display("[ERROR] o_ready: got 0x%0h, expected 0x%0h", got, want);
			value_errors++;
		end
	endtask

	task automatic drive_pair(input operand_t md, input operand_t mr, input logic start);
		@(posedge i_clk);
		#DRIVE_DELAY;
		i_md = md;
		i_mr = mr;
		i_start = start;
		if (start) begin
			expected_q.push_back(ref_product(md, mr));
		end
	endtask

	// start history as the DUT samples it
	always @(posedge i_clk) begin
		start_d2 <= start_d1;
		start_d1 <= i_start;
	end

	// ready and product compare mid-cycle
	always @(negedge i_clk) begin
		check_ready(o_ready, start_d2);
		if (o_ready) begin
			if (expected_q.size() == 0) begin
				$display("o_ready went high while no product was pending");
				other_errors++;
			end
			else begin
				popped = expected_q.pop_front();
				check_product(o_product, popped);
				last_product = popped;
			end
		end
		else begin
			// product holds during gaps
			check_product(o_product, last_product);
		end
	end

	initial begin
		i_rst = 1'b0;
		i_start = 1'b0;
		i_md = '0;
		i_mr = '0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		#DRIVE_DELAY;
		i_rst = 1'b1;

		for (int n = 0; n < NUM_DIRECTED; n++) begin
			drive_pair(dir_md[n], dir_mr[n], 1'b1);
		end
		drive_pair(operand_t'(rand_bits(OPERAND_W)),
			operand_t'(rand_bits(OPERAND_W)), 1'b0);

		// one start per cycle
		for (int n = 0; n < NUM_B2B; n++) begin
			drive_pair(operand_t'(rand_bits(OPERAND_W)),
				operand_t'(rand_bits(OPERAND_W)), 1'b1);
		end

		// gaps carry fresh operands that must not leak into results
		for (int n = 0; n < NUM_GAPPED; n++) begin
			drive_pair(operand_t'(rand_bits(OPERAND_W)), operand_t'(rand_bits(OPERAND_W)),
				rand_bits(1) == 1);
		end
		drive_pair(operand_t'(rand_bits(OPERAND_W)),
			operand_t'(rand_bits(OPERAND_W)), 1'b0);

		drain_cycles = 0;
		while (expected_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
			@(posedge i_clk);
			drain_cycles++;
		end
		if (expected_q.size() != 0) begin
			$display("timeout: %0d products never came out of the DUT", expected_q.size());
			other_errors++;
		end
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		#1;

		$display("checks run %0d, value errors %0d, other errors %0d",
			checks_run, value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("** PASS **");
		end
		else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
design/mult_pkg.sv
design/booth_pkg.sv
design/booth_encoder.sv
design/pp_generator.sv
design/csa_row.sv
design/compressor_row.sv
design/booth_multiplier.sv
tb/tb_booth_multiplier.sv

// File: Makefile
# Verilator build and run for the Booth multiplier

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_booth_multiplier
RTL_TOP   ?= booth_multiplier
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "\*\* PASS \*\*" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
